// File: Makefile
TOP := booth_multiplier_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module booth_multiplier
	verilator --lint-only -Wall --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/booth_multiplier_assert.sv
`default_nettype none

module booth_multiplier_assert (
   input wire                           CLK,
   input wire                           rst_n,
   input wire booth_mult_pkg::operand_t mx,
   input wire booth_mult_pkg::operand_t my,
   input wire booth_mult_pkg::product_t product
);

   timeunit 1ns;
   timeprecision 1ps;

   // Sampled on the falling edge, when the asynchronous clear has long settled
   reset_clears: assert property (@(negedge CLK) !rst_n |-> product == '0)
      else $error("product is not zero while reset is low");

   no_unknown_bits: assert property (@(posedge CLK) disable iff (!rst_n)
      !$isunknown(product))
      else $error("product has unknown bits after reset");

   // Equal operands on two successive edges give an unchanged result on the next edge,
   // provided the register already held a real result
   stable_result: assert property (@(posedge CLK) disable iff (!rst_n)
      $past(rst_n) && $stable(mx) && $stable(my) |=> $stable(product))
      else $error("product changed although the operands were stable");

endmodule

`default_nettype wire

// File: dv/booth_multiplier_tb.sv
`default_nettype none

module booth_multiplier_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int reset_cycles = 5;
   localparam int wait_limit   = 20;
   localparam int random_pairs = 2000;
   localparam int after_reset  = 300;

   logic                     CLK = 1'b0;
   logic                     rst_n;
   booth_mult_pkg::operand_t mx;
   booth_mult_pkg::operand_t my;
   booth_mult_pkg::product_t product;

   // Expected register contents follow the operands one cycle late and clear on reset
   booth_mult_pkg::product_t exp_product;
   int                       checked = 0;

   booth_multiplier dut (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .mx      (mx),
      .my      (my),
      .product (product)
   );

   bind booth_multiplier booth_multiplier_assert u_assert (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .mx      (mx),
      .my      (my),
      .product (product)
   );

   always #5 CLK = ~CLK;

   function automatic booth_mult_pkg::product_t ref_product(
      input booth_mult_pkg::operand_t a,
      input booth_mult_pkg::operand_t b
   );
      return booth_mult_pkg::product_t'(a) * booth_mult_pkg::product_t'(b);
   endfunction

   function automatic booth_mult_pkg::operand_t random_operand();
      return booth_mult_pkg::operand_t'($urandom);
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_product(input booth_mult_pkg::product_t expected,
                                input booth_mult_pkg::product_t actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("FAILED at %0d ns: product expected %08h, got %08h",
                                     $time, expected, actual));
      end
   endtask

   always @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         exp_product <= '0;
      end else begin
         exp_product <= ref_product(mx, my);
      end
   end

   // Product only changes on the rising edge, so the falling edge sees a settled value
   always @(negedge CLK) begin
      check_product(exp_product, product);
      checked <= checked + 1;
   end

   // Drive one operand pair on the falling edge and hold it for a number of cycles
   task automatic drive_pair(input booth_mult_pkg::operand_t a,
                             input booth_mult_pkg::operand_t b,
                             input int cycles);
      @(negedge CLK);
      mx = a;
      my = b;
      repeat (cycles - 1) @(negedge CLK);
   endtask

   task automatic wait_reset_clear();
      int waited;
      waited = 0;
      while (product !== '0) begin
         if (waited == wait_limit) begin
            stop_with_failure("Product never cleared while reset was held low");
         end
         @(posedge CLK);
         waited++;
      end
   endtask

   // Waits until the result of the last driven pair has been compared
   task automatic wait_for_results();
      int mark;
      int waited;
      @(posedge CLK);
      mark   = checked;
      waited = 0;
      while (checked < mark + 1) begin
         if (waited == wait_limit) begin
            stop_with_failure("Timed out waiting for the last product to be checked");
         end
         @(posedge CLK);
         waited++;
      end
   endtask

   task automatic run_corners();
      drive_pair(16'h0000, 16'hbeef, 1);
      drive_pair(16'h1234, 16'h0000, 1);
      drive_pair(16'h0001, 16'h8001, 1);
      drive_pair(16'hc3a5, 16'h0001, 1);
      drive_pair(16'h0001, 16'hffff, 1);
      drive_pair(16'hffff, 16'hffff, 3);
   endtask

   // Alternating and run patterns in mx hit every digit value of the recoding
   task automatic run_digit_patterns();
      booth_mult_pkg::operand_t multipliers   [0:3];
      booth_mult_pkg::operand_t multiplicands [0:4];
      multipliers   = '{16'haaaa, 16'h5555, 16'h6666, 16'h9999};
      multiplicands = '{16'h0001, 16'h7fff, 16'h8000, 16'hffff, 16'h1357};
      foreach (multipliers[i]) begin
         foreach (multiplicands[j]) begin
            drive_pair(multipliers[i], multiplicands[j], 1);
         end
      end
   endtask

   task automatic run_random(input int count);
      repeat (count) begin
         drive_pair(random_operand(), random_operand(), 1);
      end
   endtask

   // The operands keep changing while reset is low
   task automatic pulse_reset();
      @(negedge CLK);
      rst_n = 1'b0;
      mx    = random_operand();
      my    = random_operand();
      #1;
      check_product('0, product);
      repeat (reset_cycles - 1) begin
         @(negedge CLK);
         mx = random_operand();
         my = random_operand();
      end
      @(negedge CLK);
      rst_n = 1'b1;
   endtask

   initial begin
      rst_n = 1'b0;
      mx    = '0;
      my    = '0;
      void'($urandom(32'h0ac5_36b8));

      wait_reset_clear();
      repeat (reset_cycles) @(negedge CLK);
      rst_n = 1'b1;

      run_corners();
      run_digit_patterns();
      run_random(random_pairs);
      pulse_reset();
      run_random(after_reset);
      wait_for_results();

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/booth_mult_pkg.sv
`default_nettype none

package booth_mult_pkg;

   // Operand and result widths
   localparam int op_width   = 16;
   localparam int prod_width = 2 * op_width;

   // Radix-4 recoding of a zero-extended 16-bit multiplier needs one extra group
   localparam int group_cnt = op_width / 2 + 1;

   // Selected multiple is 17 bits, plus the inverted neg bit on top
   localparam int pp_width = op_width + 2;

   // Carry-save tree sizing: nine partial products and the correction row
   localparam int csa_rows   = group_cnt + 1;
   localparam int csa_layers = 5;

   // Prefix tree covers the 31 carries into bits 1 to 31
   localparam int prefix_levels = $clog2(prod_width - 1);

   // Each of the eight signed rows contributes an implicit -2^(2k+17) once its
   // sign bit is replaced by the inverted neg flag. This is the two's complement
   // of their sum; the neg flags themselves go into bits 0,2,..,14 of the row
   localparam logic [prod_width-1:0] sign_corr = 32'h5556_0000;

   typedef logic [op_width-1:0]   operand_t;
   typedef logic [prod_width-1:0] product_t;
   typedef logic [pp_width-1:0]   pp_row_t;
   typedef logic [group_cnt-1:0]  group_t;

endpackage

`default_nettype wire

// File: hw/booth_multiplier.sv
`default_nettype none

module booth_multiplier (
   input  wire                           CLK,
   input  wire                           rst_n,
   input  wire booth_mult_pkg::operand_t mx,
   input  wire booth_mult_pkg::operand_t my,
   output booth_mult_pkg::product_t      product
);

   wire booth_mult_pkg::pp_row_t  pp_rows [0:booth_mult_pkg::group_cnt-1];
   wire booth_mult_pkg::product_t corr_row;
   wire booth_mult_pkg::product_t sum_row;
   wire booth_mult_pkg::product_t carry_row;
   wire booth_mult_pkg::product_t sum;

   // Recoding, reduction and final add are all combinational
   booth_pp_gen u_pp_gen (
      .mx       (mx),
      .my       (my),
      .pp_rows  (pp_rows),
      .corr_row (corr_row)
   );

   wallace_reducer u_reducer (
      .pp_rows   (pp_rows),
      .corr_row  (corr_row),
      .sum_row   (sum_row),
      .carry_row (carry_row)
   );

   prefix_adder u_adder (
      .a   (sum_row),
      .b   (carry_row),
      .sum (sum)
   );

   // One result per clock, one cycle after the operands
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         product <= '0;
      end else begin
         product <= sum;
      end
   end

endmodule

`default_nettype wire

// File: hw/booth_pp_gen.sv
`default_nettype none

module booth_pp_gen (
   input  wire booth_mult_pkg::operand_t mx,
   input  wire booth_mult_pkg::operand_t my,
   output wire booth_mult_pkg::pp_row_t  pp_rows [0:booth_mult_pkg::group_cnt-1],
   output booth_mult_pkg::product_t      corr_row
);

   // Multiplier with the implied zero below bit 0 and zero extension on top
   wire [booth_mult_pkg::op_width+2:0] mx_ext;

   wire booth_mult_pkg::group_t single;
   wire booth_mult_pkg::group_t dbl;
   wire booth_mult_pkg::group_t neg;

   assign mx_ext = {2'b00, mx, 1'b0};

   for (genvar k = 0; k < booth_mult_pkg::group_cnt; k++) begin : g_group
      wire [2:0] win;

      // Overlapping window {mx[2k+1], mx[2k], mx[2k-1]}
      assign win = mx_ext[2*k+2:2*k];

      // Digit is +-1 when the two low bits differ, +-2 when only the top pair differs
      assign single[k] = win[0] ^ win[1];
      assign dbl[k]    = (win[1] ^ win[2]) & ~(win[0] ^ win[1]);
      assign neg[k]    = win[2];

      if (k < booth_mult_pkg::group_cnt - 1) begin : g_row
         wire [booth_mult_pkg::op_width:0] mag;

         assign mag = ({(booth_mult_pkg::op_width + 1){single[k]}} & {1'b0, my}) |
                      ({(booth_mult_pkg::op_width + 1){dbl[k]}} & {my, 1'b0});

         // One's complement here, the +1 comes in through corr_row
         assign pp_rows[k] = {~neg[k], mag ^ {(booth_mult_pkg::op_width + 1){neg[k]}}};
      end else begin : g_top_row
         wire booth_mult_pkg::operand_t top_mag;

         // Top group sees only mx[15], so this row is never negative or wider than my
         assign top_mag = ({booth_mult_pkg::op_width{single[k]}} & my) |
                          ({booth_mult_pkg::op_width{dbl[k]}} &
                           {my[booth_mult_pkg::op_width-2:0], 1'b0});

         assign pp_rows[k] = {2'b00, top_mag ^ {booth_mult_pkg::op_width{neg[k]}}};
      end
   end

   // Correction constant with the two's complement increments at even bits
   always_comb begin
      corr_row = booth_mult_pkg::sign_corr;
      for (int k = 0; k < booth_mult_pkg::group_cnt - 1; k++) begin
         corr_row[2*k] = neg[k];
      end
   end

endmodule

`default_nettype wire

// File: hw/prefix_adder.sv
`default_nettype none

module prefix_adder (
   input  wire booth_mult_pkg::product_t a,
   input  wire booth_mult_pkg::product_t b,
   output wire booth_mult_pkg::product_t sum
);

   wire booth_mult_pkg::product_t prop;

   // Group generate and propagate per level. Bit i of level l covers the
   // 2^l bits ending at i; only bits 0 to 30 feed a carry inside the result
   wire [booth_mult_pkg::prod_width-2:0] gen_lvl  [0:booth_mult_pkg::prefix_levels];
   wire [booth_mult_pkg::prod_width-2:0] prop_lvl [0:booth_mult_pkg::prefix_levels-1];

   assign prop        = a ^ b;
   assign gen_lvl[0]  = a[booth_mult_pkg::prod_width-2:0] & b[booth_mult_pkg::prod_width-2:0];
   assign prop_lvl[0] = prop[booth_mult_pkg::prod_width-2:0];

   for (genvar l = 0; l < booth_mult_pkg::prefix_levels; l++) begin : g_level
      for (genvar i = 0; i < booth_mult_pkg::prod_width - 1; i++) begin : g_bit
         if (i < (1 << l)) begin : g_hold
            // Already resolved down to bit 0
            assign gen_lvl[l+1][i] = gen_lvl[l][i];
            if (l < booth_mult_pkg::prefix_levels - 1) begin : g_prop
               assign prop_lvl[l+1][i] = prop_lvl[l][i];
            end
         end else begin : g_merge
            assign gen_lvl[l+1][i] = gen_lvl[l][i] |
                                     (prop_lvl[l][i] & gen_lvl[l][i - (1 << l)]);
            // The last level needs no group propagate
            if (l < booth_mult_pkg::prefix_levels - 1) begin : g_prop
               assign prop_lvl[l+1][i] = prop_lvl[l][i] & prop_lvl[l][i - (1 << l)];
            end
         end
      end
   end

   // Carry into bit i is the group generate of bits i-1 down to 0, with no carry-in
   assign sum = prop ^ {gen_lvl[booth_mult_pkg::prefix_levels], 1'b0};

endmodule

`default_nettype wire

// File: hw/wallace_reducer.sv
`default_nettype none

module wallace_reducer (
   input  wire booth_mult_pkg::pp_row_t  pp_rows [0:booth_mult_pkg::group_cnt-1],
   input  wire booth_mult_pkg::product_t corr_row,
   output wire booth_mult_pkg::product_t sum_row,
   output wire booth_mult_pkg::product_t carry_row
);

   // Rows entering a given layer. Every full triple turns into a sum and a
   // carry row, leftover rows pass straight through
   function automatic int rows_in(input int layer);
      int n;
      n = booth_mult_pkg::csa_rows;
      for (int l = 0; l < layer; l++) begin
         n = n - n / 3;
      end
      return n;
   endfunction

   // Row l of the array holds the weighted rows entering layer l, all 32 bits wide.
   // Row counts per layer run 10, 7, 5, 4, 3 and end at 2
   wire booth_mult_pkg::product_t row
      [0:booth_mult_pkg::csa_layers][0:booth_mult_pkg::csa_rows-1];

   // Partial product k sits at bit offset 2k
   for (genvar k = 0; k < booth_mult_pkg::group_cnt; k++) begin : g_place
      assign row[0][k] = booth_mult_pkg::product_t'(pp_rows[k]) << (2 * k);
   end

   assign row[0][booth_mult_pkg::csa_rows-1] = corr_row;

   for (genvar l = 0; l < booth_mult_pkg::csa_layers; l++) begin : g_layer

      // Full adders across the whole width, three rows at a time
      for (genvar g = 0; g < rows_in(l) / 3; g++) begin : g_csa
         wire booth_mult_pkg::product_t in_a;
         wire booth_mult_pkg::product_t in_b;
         wire booth_mult_pkg::product_t in_c;

         assign in_a = row[l][3*g];
         assign in_b = row[l][3*g+1];
         assign in_c = row[l][3*g+2];

         assign row[l+1][2*g] = in_a ^ in_b ^ in_c;

         // Carries weigh one bit more; the carry out of bit 31 is beyond the product
         assign row[l+1][2*g+1] = ((in_a & in_b) | (in_a & in_c) | (in_b & in_c)) << 1;
      end

      // Rows left over after the last triple move down behind the new pairs
      for (genvar r = 3 * (rows_in(l) / 3); r < rows_in(l); r++) begin : g_pass
         assign row[l+1][r - rows_in(l) / 3] = row[l][r];
      end

      // Slots no longer in use
      for (genvar r = rows_in(l + 1); r < booth_mult_pkg::csa_rows; r++) begin : g_idle
         assign row[l+1][r] = '0;
      end
   end

   assign sum_row   = row[booth_mult_pkg::csa_layers][0];
   assign carry_row = row[booth_mult_pkg::csa_layers][1];

endmodule

`default_nettype wire

// File: tb.f
hw/booth_mult_pkg.sv
hw/booth_pp_gen.sv
hw/wallace_reducer.sv
hw/prefix_adder.sv
hw/booth_multiplier.sv
dv/booth_multiplier_assert.sv
dv/booth_multiplier_tb.sv
